//--- rtl/soc_pkg.sv
/* I/O map word indices, timer and video constants,
   SDRAM command encoding and the two-view SDRAM address word */
`default_nettype none

package soc_pkg;

    localparam logic [3:0] IO_PAGE = 4'hE;  // adr[31:28] of the I/O page

    // word index in adr[5:2]
    localparam logic [3:0] IO_MS        = 4'd0;
    localparam logic [3:0] IO_LED       = 4'd1;
    localparam logic [3:0] IO_UART_DATA = 4'd2;
    localparam logic [3:0] IO_UART_STAT = 4'd3;  // status on read, bitrate on write
    localparam logic [3:0] IO_SPI_DATA  = 4'd4;
    localparam logic [3:0] IO_SPI_STAT  = 4'd5;  // status on read, control on write
    localparam logic [3:0] IO_MOUSE     = 4'd6;
    localparam logic [3:0] IO_KBD       = 4'd7;
    localparam logic [3:0] IO_GFX       = 4'd8;
    localparam logic [3:0] IO_RES       = 4'd9;

    localparam int unsigned CLK_FREQ_HZ = 25_000_000;
    localparam logic [16:0] MS_TICKS    = 17'(CLK_FREQ_HZ / 1000);  // cycles per ms

    // fixed 640x480 mode
    localparam logic [15:0] H_RES = 16'd640;
    localparam logic [15:0] V_RES = 16'd480;

    // 32-byte video lines per frame, 16 bpp
    localparam logic [18:0] VID_LINE_LAST = 19'(int'(H_RES) * int'(V_RES) * 2 / 32 - 1);

    typedef enum logic [1:0] {
        SDR_NOP     = 2'd0,
        SDR_WR_LINE = 2'd1,  // 256 bytes from cache
        SDR_RD_VID  = 2'd2,  // 32 bytes for video
        SDR_RD_LINE = 2'd3   // 256 bytes into cache
    } sdr_cmd_e;

    typedef union packed {
        struct packed {
            logic [16:0] line;
            logic [5:0]  offset;
        } cache;
        struct packed {
            logic        region;  // set for the video area
            logic [18:0] line;
            logic [2:0]  offset;
        } video;
    } sdram_addr_u;

endpackage

`default_nettype wire

//--- rtl/io_bus_if.sv
/* internal CPU-side I/O bus: address, strobes and data */
`timescale 1ns/1ps
`default_nettype none

interface io_bus_if;

    logic [31:0] adr;    // full byte address
    logic        wr;     // single cycle write strobe
    logic        rd;     // single cycle read strobe
    logic [31:0] wdata;
    logic [31:0] rdata;  // valid in the cycle of rd

    // driver side of the bus
    modport host (
        output adr,
        output wr,
        output rd,
        output wdata,
        input  rdata
    );

    // register block side
    modport dev (
        input  adr,
        input  wr,
        input  rd,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- rtl/ms_timer.sv
/* millisecond system timer with cycle prescaler */
`timescale 1ns/1ps
`default_nettype none

module ms_timer (
    input  wire logic        clk_cpu,
    input  wire logic        rst_n,
    output logic      [31:0] ms_count_o
);
    import soc_pkg::*;

    logic [16:0] presc_q;
    logic        ms_tick;

    assign ms_tick = (presc_q == MS_TICKS - 17'd1);  // last cycle of the ms

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            presc_q    <= '0;
            ms_count_o <= '0;
        end else begin
            if (ms_tick) begin
                presc_q    <= '0;
                ms_count_o <= ms_count_o + 32'd1;
            end else begin
                presc_q <= presc_q + 17'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/io_regs.sv
/* I/O page decode, LED / bitrate / SPI control registers,
   start strobes, graphics command, read mux and read-done pulses */
`timescale 1ns/1ps
`default_nettype none

module io_regs (
    input  wire logic        clk_cpu,
    input  wire logic        rst_n,
    io_bus_if.dev            bus,
    input  wire logic [31:0] ms_count_i,
    // peripheral status
    input  wire logic [7:0]  rx_data_i,
    input  wire logic        rx_rdy_i,
    input  wire logic        tx_rdy_i,
    input  wire logic [31:0] spi_rx_i,
    input  wire logic        spi_rdy_i,
    input  wire logic [7:0]  kbd_data_i,
    input  wire logic        kbd_rdy_i,
    input  wire logic [27:0] mouse_i,
    input  wire logic        gfx_ready_i,
    // peripheral control
    output logic      [7:0]  led_o,
    output logic             bitrate_o,
    output logic      [1:0]  spi_ss_n_o,
    output logic             spi_fast_o,
    output logic             tx_start_o,
    output logic             spi_start_o,
    output logic             rx_done_o,
    output logic             kbd_done_o,
    output logic             gfx_cmd_valid_o,
    output logic      [31:0] gfx_cmd_data_o
);
    import soc_pkg::*;

    logic       io_sel;
    logic [3:0] io_idx;
    logic       io_wr;
    logic       io_rd;

    assign io_sel = (bus.adr[31:28] == IO_PAGE);
    assign io_idx = bus.adr[5:2];  // word index
    assign io_wr  = bus.wr & io_sel;
    assign io_rd  = bus.rd & io_sel;

    // engines take their data straight from the bus
    assign tx_start_o  = io_wr & (io_idx == IO_UART_DATA);
    assign spi_start_o = io_wr & (io_idx == IO_SPI_DATA);

    // control registers
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            led_o      <= 8'd0;
            bitrate_o  <= 1'b0;
            spi_ss_n_o <= 2'b11;  // no slave selected
            spi_fast_o <= 1'b0;
        end else if (io_wr) begin
            case (io_idx)
                IO_LED:       led_o <= bus.wdata[7:0];
                IO_UART_STAT: bitrate_o <= bus.wdata[0];
                IO_SPI_STAT: begin
                    spi_ss_n_o <= ~bus.wdata[1:0];  // active low selects
                    spi_fast_o <= bus.wdata[2];
                end
                default: ;
            endcase
        end
    end

    // graphics command, one cycle valid
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            gfx_cmd_valid_o <= 1'b0;
        end else begin
            gfx_cmd_valid_o <= io_wr & (io_idx == IO_GFX);
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (io_wr && io_idx == IO_GFX) begin
            gfx_cmd_data_o <= bus.wdata;
        end
    end

    // tell the receivers their data has been taken
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            rx_done_o  <= 1'b0;
            kbd_done_o <= 1'b0;
        end else begin
            rx_done_o  <= io_rd & (io_idx == IO_UART_DATA);
            kbd_done_o <= io_rd & (io_idx == IO_KBD);
        end
    end

    // read mux
    always_comb begin
        bus.rdata = 32'd0;
        if (io_sel) begin
            case (io_idx)
                IO_MS:        bus.rdata = ms_count_i;
                IO_UART_DATA: bus.rdata = {24'd0, rx_data_i};
                IO_UART_STAT: bus.rdata = {30'd0, tx_rdy_i, rx_rdy_i};
                IO_SPI_DATA:  bus.rdata = spi_rx_i;
                IO_SPI_STAT:  bus.rdata = {31'd0, spi_rdy_i};
                IO_MOUSE:     bus.rdata = {3'd0, kbd_rdy_i, mouse_i};
                IO_KBD:       bus.rdata = {24'd0, kbd_data_i};
                IO_GFX:       bus.rdata = {31'd0, gfx_ready_i};
                IO_RES:       bus.rdata = {H_RES, V_RES};
                default:      bus.rdata = 32'd0;  // LED word and unused slots
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/sdram_cmd_arb.sv
/* SDRAM command arbiter: video / cache write / cache read priority,
   frame-wrapping video line counter and SDRAM word address */
`timescale 1ns/1ps
`default_nettype none

module sdram_cmd_arb (
    input  wire logic             clk_cpu,
    input  wire logic             rst_n,
    input  wire logic             vq_low_i,        // video queue below low water
    input  wire logic             cache_wr_req_i,
    input  wire logic             cache_rd_req_i,
    input  wire logic      [16:0] cache_line_i,
    input  wire logic      [18:0] front_line_i,    // start of the front buffer
    input  wire logic      [1:0]  sdr_ack_i,
    output soc_pkg::sdr_cmd_e     sdr_cmd_o,
    output logic           [22:0] sdr_addr_o
);
    import soc_pkg::*;

    logic        ack_idle_q;  // previous ack was 00
    logic [18:0] vid_line_q;
    logic [18:0] vid_line_abs;
    sdram_addr_u addr_u;

    // video refill first so the screen never starves
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            sdr_cmd_o <= SDR_NOP;
        end else if (vq_low_i) begin
            sdr_cmd_o <= SDR_RD_VID;
        end else if (cache_wr_req_i) begin
            sdr_cmd_o <= SDR_WR_LINE;
        end else if (cache_rd_req_i) begin
            sdr_cmd_o <= SDR_RD_LINE;
        end else begin
            sdr_cmd_o <= SDR_NOP;
        end
    end

    // step the video line once per accepted video read
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            ack_idle_q <= 1'b1;
            vid_line_q <= 19'd0;
        end else begin
            ack_idle_q <= (sdr_ack_i == 2'b00);
            if (ack_idle_q && sdr_ack_i == SDR_RD_VID) begin
                if (vid_line_q == VID_LINE_LAST) begin
                    vid_line_q <= 19'd0;  // frame done
                end else begin
                    vid_line_q <= vid_line_q + 19'd1;
                end
            end
        end
    end

    assign vid_line_abs = front_line_i + vid_line_q;  // wraps in 19 bits

    always_comb begin
        addr_u = '0;
        case (sdr_cmd_o)
            SDR_WR_LINE, SDR_RD_LINE: begin
                addr_u.cache.line   = cache_line_i;
                addr_u.cache.offset = 6'd0;
            end
            SDR_RD_VID: begin
                addr_u.video.region = 1'b1;
                addr_u.video.line   = vid_line_abs;
                addr_u.video.offset = 3'd0;
            end
            default: addr_u = '0;
        endcase
    end

    assign sdr_addr_o = addr_u;

endmodule

`default_nettype wire

//--- rtl/soc_io_top.sv
/* I/O and SDRAM command top level: ms timer, I/O register block
   and SDRAM arbiter on clk_cpu */
`timescale 1ns/1ps
`default_nettype none

module soc_io_top (
    input  wire logic             clk_cpu,
    input  wire logic             rst_n,
    // CPU I/O bus
    input  wire logic      [31:0] io_adr_i,
    input  wire logic             io_wr_i,
    input  wire logic             io_rd_i,
    input  wire logic      [31:0] io_wdata_i,
    output logic           [31:0] io_rdata_o,
    // peripheral status
    input  wire logic      [7:0]  rx_data_i,
    input  wire logic             rx_rdy_i,
    input  wire logic             tx_rdy_i,
    input  wire logic      [31:0] spi_rx_i,
    input  wire logic             spi_rdy_i,
    input  wire logic      [7:0]  kbd_data_i,
    input  wire logic             kbd_rdy_i,
    input  wire logic      [27:0] mouse_i,
    input  wire logic             gfx_ready_i,
    // peripheral control
    output logic           [7:0]  led_o,
    output logic                  bitrate_o,
    output logic           [1:0]  spi_ss_n_o,
    output logic                  spi_fast_o,
    output logic                  tx_start_o,
    output logic                  spi_start_o,
    output logic                  rx_done_o,
    output logic                  kbd_done_o,
    output logic                  gfx_cmd_valid_o,
    output logic           [31:0] gfx_cmd_data_o,
    // SDRAM command side
    input  wire logic             vq_low_i,
    input  wire logic             cache_wr_req_i,
    input  wire logic             cache_rd_req_i,
    input  wire logic      [16:0] cache_line_i,
    input  wire logic      [18:0] front_line_i,
    input  wire logic      [1:0]  sdr_ack_i,
    output soc_pkg::sdr_cmd_e     sdr_cmd_o,
    output logic           [22:0] sdr_addr_o
);

    logic [31:0] ms_count;

    io_bus_if bus ();

    assign bus.adr    = io_adr_i;
    assign bus.wr     = io_wr_i;
    assign bus.rd     = io_rd_i;
    assign bus.wdata  = io_wdata_i;
    assign io_rdata_o = bus.rdata;

    ms_timer i_ms_timer (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .ms_count_o (ms_count)
    );

    io_regs i_io_regs (
        .clk_cpu         (clk_cpu),
        .rst_n           (rst_n),
        .bus             (bus),
        .ms_count_i      (ms_count),
        .rx_data_i       (rx_data_i),
        .rx_rdy_i        (rx_rdy_i),
        .tx_rdy_i        (tx_rdy_i),
        .spi_rx_i        (spi_rx_i),
        .spi_rdy_i       (spi_rdy_i),
        .kbd_data_i      (kbd_data_i),
        .kbd_rdy_i       (kbd_rdy_i),
        .mouse_i         (mouse_i),
        .gfx_ready_i     (gfx_ready_i),
        .led_o           (led_o),
        .bitrate_o       (bitrate_o),
        .spi_ss_n_o      (spi_ss_n_o),
        .spi_fast_o      (spi_fast_o),
        .tx_start_o      (tx_start_o),
        .spi_start_o     (spi_start_o),
        .rx_done_o       (rx_done_o),
        .kbd_done_o      (kbd_done_o),
        .gfx_cmd_valid_o (gfx_cmd_valid_o),
        .gfx_cmd_data_o  (gfx_cmd_data_o)
    );

    sdram_cmd_arb i_sdram_cmd_arb (
        .clk_cpu        (clk_cpu),
        .rst_n          (rst_n),
        .vq_low_i       (vq_low_i),
        .cache_wr_req_i (cache_wr_req_i),
        .cache_rd_req_i (cache_rd_req_i),
        .cache_line_i   (cache_line_i),
        .front_line_i   (front_line_i),
        .sdr_ack_i      (sdr_ack_i),
        .sdr_cmd_o      (sdr_cmd_o),
        .sdr_addr_o     (sdr_addr_o)
    );

endmodule

`default_nettype wire

//--- bench/tb_checks.svh
/* LFSR random source, compare tasks typed to the DUT outputs,
   per-test and total check counting */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

logic [31:0] lfsr_q      = 32'd81099;
int unsigned check_count = 0;
int unsigned err_count   = 0;
int unsigned test_count  = 0;
int unsigned test_checks = 0;
int unsigned test_errs   = 0;

// galois form, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
        val = {val[30:0], lfsr_q[0]};
        if (lfsr_q[0]) begin
            lfsr_q = (lfsr_q >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_q = lfsr_q >> 1;
        end
    end
    return val;
endfunction

task automatic count_check(input logic ok);
    check_count++;
    test_checks++;
    if (!ok) begin
        err_count++;
        test_errs++;
    end
endtask

task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
    count_check(got === exp);
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
    count_check(got === exp);
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERR t=%0t %s: got %b, expected %b", $time, name, got, exp);
    end
    count_check(got === exp);
endtask

task automatic check_cmd(input string name, input sdr_cmd_e got, input sdr_cmd_e exp);
    if (got !== exp) begin
        $display("ERR t=%0t %s: got %s (%0d), expected %s (%0d)",
                 $time, name, got.name(), got, exp.name(), exp);
    end
    count_check(got === exp);
endtask

task automatic check_addr(input string name, input sdram_addr_u got, input sdram_addr_u exp);
    if (got !== exp) begin
        $display("ERR t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
    count_check(got === exp);
endtask

// a failure that is not a value mismatch
task automatic fail_check(input string msg);
    $display("%s", msg);
    count_check(1'b0);
endtask

task automatic report_test(input string name);
    test_count++;
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errs);
    test_checks = 0;
    test_errs   = 0;
endtask

`endif

//--- bench/tb_soc_io.sv
/* testbench for soc_io_top: clock and reset, LFSR stimulus,
   reference model of the I/O map, timer and SDRAM arbiter, test sequence */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_io;
    import soc_pkg::*;

    logic        clk_cpu = 1'b0;
    logic        rst_n;
    logic [31:0] io_adr_i;
    logic        io_wr_i;
    logic        io_rd_i;
    logic [31:0] io_wdata_i;
    logic [31:0] io_rdata_o;
    logic [7:0]  rx_data_i;
    logic        rx_rdy_i;
    logic        tx_rdy_i;
    logic [31:0] spi_rx_i;
    logic        spi_rdy_i;
    logic [7:0]  kbd_data_i;
    logic        kbd_rdy_i;
    logic [27:0] mouse_i;
    logic        gfx_ready_i;
    logic [7:0]  led_o;
    logic        bitrate_o;
    logic [1:0]  spi_ss_n_o;
    logic        spi_fast_o;
    logic        tx_start_o;
    logic        spi_start_o;
    logic        rx_done_o;
    logic        kbd_done_o;
    logic        gfx_cmd_valid_o;
    logic [31:0] gfx_cmd_data_o;
    logic        vq_low_i;
    logic        cache_wr_req_i;
    logic        cache_rd_req_i;
    logic [16:0] cache_line_i;
    logic [18:0] front_line_i;
    logic [1:0]  sdr_ack_i;
    sdr_cmd_e    sdr_cmd_o;
    logic [22:0] sdr_addr_o;

    // reference model state
    logic [7:0]  led_m;
    logic        bitrate_m;
    logic [1:0]  ss_n_m;
    logic        fast_m;
    logic [18:0] vid_line_m;
    logic [31:0] cyc;  // cycles with rst_n high

    `include "tb_checks.svh"

    soc_io_top i_soc_io_top (.*);

    always #4 clk_cpu = ~clk_cpu;

    always @(posedge clk_cpu) begin
        if (!rst_n) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 32'd1;
        end
    end

    function automatic logic in_page(input logic [31:0] adr);
        return adr[31:28] == IO_PAGE;
    endfunction

    function automatic logic [31:0] rand_adr(input logic sel, input logic [3:0] idx);
        logic [3:0] page;
        page = 4'(rand_bits(4));
        if (sel) begin
            page = IO_PAGE;
        end else if (page == IO_PAGE) begin
            page = 4'h2;  // keep it off the I/O page
        end
        return {page, 22'(rand_bits(22)), idx, 2'(rand_bits(2))};
    endfunction

    function automatic logic [31:0] exp_read(input logic [31:0] adr);
        if (!in_page(adr)) return 32'd0;
        case (adr[5:2])
            IO_MS:        return cyc / 32'(MS_TICKS);
            IO_UART_DATA: return {24'd0, rx_data_i};
            IO_UART_STAT: return {30'd0, tx_rdy_i, rx_rdy_i};
            IO_SPI_DATA:  return spi_rx_i;
            IO_SPI_STAT:  return {31'd0, spi_rdy_i};
            IO_MOUSE:     return {3'd0, kbd_rdy_i, mouse_i};
            IO_KBD:       return {24'd0, kbd_data_i};
            IO_GFX:       return {31'd0, gfx_ready_i};
            IO_RES:       return 32'h0280_01E0;  // 640 x 480
            default:      return 32'd0;
        endcase
    endfunction

    function automatic sdr_cmd_e exp_cmd(input logic vq, input logic wr, input logic rd);
        if (vq) return SDR_RD_VID;
        if (wr) return SDR_WR_LINE;
        if (rd) return SDR_RD_LINE;
        return SDR_NOP;
    endfunction

    function automatic logic [22:0] exp_addr(input sdr_cmd_e cmd);
        logic [18:0] line;
        line = front_line_i + vid_line_m;
        case (cmd)
            SDR_WR_LINE, SDR_RD_LINE: return {cache_line_i, 6'd0};
            SDR_RD_VID:               return {1'b1, line, 3'd0};
            default:                  return 23'd0;
        endcase
    endfunction

    task automatic wait_cycle(input logic [31:0] target, input int unsigned limit);
        int unsigned waited;
        waited = 0;
        do begin
            @(negedge clk_cpu);
            waited++;
        end while (cyc != target && waited < limit);
        if (cyc != target) begin
            fail_check($sformatf("timeout: cycle %0d after reset release never came", target));
        end
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] data);
        logic       sel;
        logic [3:0] idx;
        sel = in_page(adr);
        idx = adr[5:2];
        @(posedge clk_cpu);
        io_adr_i   <= adr;
        io_wdata_i <= data;
        io_wr_i    <= 1'b1;
        @(negedge clk_cpu);
        check_bit("tx_start_o", tx_start_o, sel && idx == IO_UART_DATA);
        check_bit("spi_start_o", spi_start_o, sel && idx == IO_SPI_DATA);
        if (sel) begin
            case (idx)
                IO_LED:       led_m = data[7:0];
                IO_UART_STAT: bitrate_m = data[0];
                IO_SPI_STAT: begin
                    ss_n_m = ~data[1:0];
                    fast_m = data[2];
                end
                default: ;
            endcase
        end
        @(posedge clk_cpu);
        io_wr_i <= 1'b0;
        @(negedge clk_cpu);
        check_byte("led_o", led_o, led_m);
        check_bit("bitrate_o", bitrate_o, bitrate_m);
        check_bit("spi_ss_n_o[1]", spi_ss_n_o[1], ss_n_m[1]);
        check_bit("spi_ss_n_o[0]", spi_ss_n_o[0], ss_n_m[0]);
        check_bit("spi_fast_o", spi_fast_o, fast_m);
        check_bit("gfx_cmd_valid_o", gfx_cmd_valid_o, sel && idx == IO_GFX);
        if (sel && idx == IO_GFX) begin
            check_word("gfx_cmd_data_o", gfx_cmd_data_o, data);
        end
        check_bit("rx_done_o", rx_done_o, 1'b0);
        check_bit("kbd_done_o", kbd_done_o, 1'b0);
        check_bit("tx_start_o", tx_start_o, 1'b0);
        check_bit("spi_start_o", spi_start_o, 1'b0);
        @(posedge clk_cpu);
        @(negedge clk_cpu);
        check_bit("gfx_cmd_valid_o", gfx_cmd_valid_o, 1'b0);  // single cycle
    endtask

    task automatic bus_read(input logic [31:0] adr);
        logic sel;
        sel = in_page(adr);
        @(posedge clk_cpu);
        io_adr_i <= adr;
        io_rd_i  <= 1'b1;
        @(negedge clk_cpu);
        check_word("io_rdata_o", io_rdata_o, exp_read(adr));
        @(posedge clk_cpu);
        io_rd_i <= 1'b0;
        @(negedge clk_cpu);
        check_bit("rx_done_o", rx_done_o, sel && adr[5:2] == IO_UART_DATA);
        check_bit("kbd_done_o", kbd_done_o, sel && adr[5:2] == IO_KBD);
        @(posedge clk_cpu);
        @(negedge clk_cpu);
        check_bit("rx_done_o", rx_done_o, 1'b0);
        check_bit("kbd_done_o", kbd_done_o, 1'b0);
    endtask

    task automatic drive_status();
        @(posedge clk_cpu);
        rx_data_i   <= 8'(rand_bits(8));
        rx_rdy_i    <= 1'(rand_bits(1));
        tx_rdy_i    <= 1'(rand_bits(1));
        spi_rx_i    <= rand_bits(32);
        spi_rdy_i   <= 1'(rand_bits(1));
        kbd_data_i  <= 8'(rand_bits(8));
        kbd_rdy_i   <= 1'(rand_bits(1));
        mouse_i     <= 28'(rand_bits(28));
        gfx_ready_i <= 1'(rand_bits(1));
    endtask

    initial begin
        logic     wrapped;
        sdr_cmd_e cmd_m;
        rst_n          <= 1'b0;
        io_adr_i       <= {IO_PAGE, 28'd0};  // word 0 held for the timer test
        io_rd_i        <= 1'b1;
        io_wr_i        <= 1'b0;
        io_wdata_i     <= '0;
        rx_data_i      <= '0;
        rx_rdy_i       <= 1'b0;
        tx_rdy_i       <= 1'b0;
        spi_rx_i       <= '0;
        spi_rdy_i      <= 1'b0;
        kbd_data_i     <= '0;
        kbd_rdy_i      <= 1'b0;
        mouse_i        <= '0;
        gfx_ready_i    <= 1'b0;
        vq_low_i       <= 1'b1;  // must be ignored in reset
        cache_wr_req_i <= 1'b0;
        cache_rd_req_i <= 1'b0;
        cache_line_i   <= '0;
        front_line_i   <= '0;
        sdr_ack_i      <= 2'd0;
        led_m      = 8'd0;
        bitrate_m  = 1'b0;
        ss_n_m     = 2'b11;
        fast_m     = 1'b0;
        vid_line_m = '0;

        repeat (15) @(posedge clk_cpu);
        @(negedge clk_cpu);
        check_cmd("sdr_cmd_o", sdr_cmd_o, SDR_NOP);
        check_byte("led_o", led_o, 8'd0);
        check_bit("bitrate_o", bitrate_o, 1'b0);
        check_bit("spi_ss_n_o[1]", spi_ss_n_o[1], 1'b1);
        check_bit("spi_ss_n_o[0]", spi_ss_n_o[0], 1'b1);
        check_bit("spi_fast_o", spi_fast_o, 1'b0);
        check_bit("gfx_cmd_valid_o", gfx_cmd_valid_o, 1'b0);
        check_bit("rx_done_o", rx_done_o, 1'b0);
        check_bit("kbd_done_o", kbd_done_o, 1'b0);
        @(posedge clk_cpu);
        rst_n    <= 1'b1;
        vq_low_i <= 1'b0;
        report_test("reset");

        wait_cycle(32'd0, 4);
        check_word("io_rdata_o", io_rdata_o, 32'd0);
        wait_cycle(32'(MS_TICKS) - 32'd1, 32'(MS_TICKS) + 4);
        check_word("io_rdata_o", io_rdata_o, 32'd0);
        wait_cycle(32'(MS_TICKS), 4);
        check_word("io_rdata_o", io_rdata_o, 32'd1);
        wait_cycle(32'(MS_TICKS) * 4, 32'(MS_TICKS) * 3 + 4);
        check_word("io_rdata_o", io_rdata_o, 32'd4);
        @(posedge clk_cpu);
        io_rd_i <= 1'b0;
        report_test("ms_timer");

        for (int i = 0; i < 16; i++) begin
            bus_write(rand_adr(1'b1, 4'(i)), rand_bits(32));
        end
        for (int i = 0; i < 200; i++) begin
            bus_write(rand_adr(1'(rand_bits(1)), 4'(rand_bits(4))), rand_bits(32));
        end
        report_test("io_writes");

        for (int r = 0; r < 6; r++) begin
            drive_status();
            for (int i = 0; i < 32; i++) begin
                bus_read(rand_adr(i < 16, 4'(i)));
            end
        end
        report_test("read_map");

        for (int i = 0; i < 300; i++) begin
            @(posedge clk_cpu);
            vq_low_i       <= 1'(rand_bits(1));
            cache_wr_req_i <= 1'(rand_bits(1));
            cache_rd_req_i <= 1'(rand_bits(1));
            cache_line_i   <= 17'(rand_bits(17));
            front_line_i   <= 19'(rand_bits(19));
            @(posedge clk_cpu);
            @(negedge clk_cpu);
            cmd_m = exp_cmd(vq_low_i, cache_wr_req_i, cache_rd_req_i);
            check_cmd("sdr_cmd_o", sdr_cmd_o, cmd_m);
            check_addr("sdr_addr_o", sdr_addr_o, exp_addr(cmd_m));
        end
        report_test("arbiter");

        @(posedge clk_cpu);
        vq_low_i     <= 1'b1;  // keep the video view on the address
        front_line_i <= '0;
        wrapped = 1'b0;
        for (int i = 0; i < int'(VID_LINE_LAST) + 2; i++) begin
            @(posedge clk_cpu);
            sdr_ack_i <= 2'd2;
            @(posedge clk_cpu);
            sdr_ack_i <= 2'd0;
            if (vid_line_m == VID_LINE_LAST) begin
                vid_line_m = '0;
            end else begin
                vid_line_m = vid_line_m + 19'd1;
            end
            @(negedge clk_cpu);
            check_addr("sdr_addr_o", sdr_addr_o, exp_addr(SDR_RD_VID));
            if (sdr_addr_o == {1'b1, 19'd0, 3'd0}) begin
                wrapped = 1'b1;  // DUT back on line 0
            end
        end
        if (!wrapped) begin
            fail_check("video address never returned to line 0");
        end
        report_test("video_wrap");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+bench
rtl/soc_pkg.sv
rtl/io_bus_if.sv
rtl/ms_timer.sv
rtl/io_regs.sv
rtl/sdram_cmd_arb.sv
rtl/soc_io_top.sv
bench/tb_soc_io.sv

//--- run_sim.sh
#!/bin/sh
# build and run the soc_io testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_soc_io \
    -f sim.f -o tb_soc_io
./obj_dir/tb_soc_io > sim.log 2>&1
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
